//--- verilog/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and instruction width
`define WORD_W 32

// register file geometry
`define REG_CNT 32
`define REG_AW 5

`endif

//--- verilog/cpuPkg.sv
`include "cpu_cfg.svh"

package cpuPkg;

  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,  // start of the I-type range
    BNE   = 6'b000101,
    ADDI  = 6'b001000,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    SLTIU = 6'b001011,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    LL    = 6'b110000,
    SC    = 6'b111000,  // end of the I-type range
    HALT  = 6'b111111
  } opcodeT;

  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    JR   = 6'b001000,
    ADD  = 6'b100000,
    ADDU = 6'b100001,
    SUB  = 6'b100010,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    NOR  = 6'b100111,
    SLT  = 6'b101010,
    SLTU = 6'b101011
  } functT;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL
  } aluOpT;

  typedef enum logic [1:0] {RD, RT, R31} regDstT;
  typedef enum logic [1:0] {ALUO, DLOAD, PORTB, NPC} wbSelT;
  typedef enum logic [1:0] {ZEROEXT, SIGNEXT, LUIEXT, SHAMEXT} extOpT;

  // instruction class that steers shifts and control flow
  typedef enum logic [3:0] {
    OTHERR, OTHERI, OJR, OSL, OBEQ, OBNE, OLUI, OLW, OSW, OJ, OJAL
  } opFuncT;

  typedef struct packed {
    opcodeT              opcode;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`REG_AW-1:0] rd;
    logic [4:0]          shamt;
    functT               funct;
  } rInstrT;

  typedef struct packed {
    opcodeT              opcode;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [15:0]         imm;
  } iInstrT;

  typedef struct packed {
    opcodeT      opcode;
    logic [25:0] index;
  } jInstrT;

  typedef struct packed {
    regDstT regDst;
    logic   aluSrc;
    wbSelT  wbSel;
    logic   regWen;
    logic   dWen;
    logic   dRen;
    aluOpT  aluOp;
    extOpT  extOp;
    opFuncT opFunc;
    logic   halt;
  } ctrlT;

  typedef struct packed {
    logic               dRen;
    logic               dWen;
    logic [`WORD_W-1:0] addr;
    logic [`WORD_W-1:0] storeData;
  } memReqT;

  typedef struct packed {
    logic               taken;
    logic [`WORD_W-1:0] target;
  } redirectT;

  typedef struct packed {
    logic               wen;
    logic [`REG_AW-1:0] addr;
    logic [`WORD_W-1:0] data;
  } regWriteT;

endpackage

//--- verilog/controlUnit.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module controlUnit (
  input  logic [`WORD_W-1:0] instr,
  output cpuPkg::ctrlT       ctrl
);

  cpuPkg::rInstrT rInstr;
  cpuPkg::iInstrT iInstr;
  cpuPkg::jInstrT jInstr;

  logic isR, isI, isJ, isHalt;

  assign rInstr = cpuPkg::rInstrT'(instr);
  assign iInstr = cpuPkg::iInstrT'(instr);
  assign jInstr = cpuPkg::jInstrT'(instr);

  // instruction class
  always_comb begin
    isR = (rInstr.opcode == cpuPkg::RTYPE);
    isJ = (jInstr.opcode == cpuPkg::J) || (jInstr.opcode == cpuPkg::JAL);
    isHalt = (iInstr.opcode == cpuPkg::HALT);
    case (iInstr.opcode)
      cpuPkg::BEQ, cpuPkg::BNE, cpuPkg::ADDI, cpuPkg::ADDIU, cpuPkg::SLTI,
      cpuPkg::SLTIU, cpuPkg::ANDI, cpuPkg::ORI, cpuPkg::XORI, cpuPkg::LUI,
      cpuPkg::LW, cpuPkg::SW, cpuPkg::LL, cpuPkg::SC: isI = 1'b1;
      default: isI = 1'b0;  // holes in the range are not I-type
    endcase
  end

  always_comb begin
    // default path does nothing
    ctrl.regDst = cpuPkg::R31;
    ctrl.aluSrc = 1'b0;
    ctrl.wbSel  = cpuPkg::NPC;
    ctrl.regWen = 1'b0;
    ctrl.dWen   = 1'b0;
    ctrl.dRen   = 1'b0;
    ctrl.aluOp  = cpuPkg::ALU_AND;
    ctrl.extOp  = cpuPkg::ZEROEXT;
    ctrl.opFunc = cpuPkg::OTHERI;
    ctrl.halt   = 1'b0;

    if (isR) begin
      ctrl.regDst = cpuPkg::RD;
      ctrl.wbSel  = cpuPkg::ALUO;
      ctrl.regWen = 1'b1;
      ctrl.extOp  = cpuPkg::SHAMEXT;
      ctrl.opFunc = cpuPkg::OTHERR;

      if (rInstr.funct == cpuPkg::JR) begin
        ctrl.opFunc = cpuPkg::OJR;
        ctrl.regWen = 1'b0;
      end

      // shamt comes in through port B
      if (rInstr.funct == cpuPkg::SLL || rInstr.funct == cpuPkg::SRL) begin
        ctrl.opFunc = cpuPkg::OSL;
        ctrl.aluSrc = 1'b1;
      end

      case (rInstr.funct)
        cpuPkg::ADD, cpuPkg::ADDU: ctrl.aluOp = cpuPkg::ALU_ADD;
        cpuPkg::SUB, cpuPkg::SUBU: ctrl.aluOp = cpuPkg::ALU_SUB;
        cpuPkg::AND:  ctrl.aluOp = cpuPkg::ALU_AND;
        cpuPkg::OR:   ctrl.aluOp = cpuPkg::ALU_OR;
        cpuPkg::XOR:  ctrl.aluOp = cpuPkg::ALU_XOR;
        cpuPkg::NOR:  ctrl.aluOp = cpuPkg::ALU_NOR;
        cpuPkg::SLT:  ctrl.aluOp = cpuPkg::ALU_SLT;
        cpuPkg::SLTU: ctrl.aluOp = cpuPkg::ALU_SLTU;
        cpuPkg::SLL:  ctrl.aluOp = cpuPkg::ALU_SLL;
        cpuPkg::SRL:  ctrl.aluOp = cpuPkg::ALU_SRL;
        cpuPkg::JR:   ctrl.aluOp = cpuPkg::ALU_ADD;
        default: begin
          ctrl.aluOp  = cpuPkg::ALU_AND;
          ctrl.regWen = 1'b0;  // unknown funct writes nothing
        end
      endcase
    end else if (isI) begin
      ctrl.regDst = cpuPkg::RT;
      ctrl.aluSrc = 1'b1;
      ctrl.wbSel  = cpuPkg::ALUO;
      ctrl.regWen = 1'b1;
      ctrl.extOp  = cpuPkg::SIGNEXT;
      ctrl.opFunc = cpuPkg::OTHERI;

      // branches compare rs against rt
      if (iInstr.opcode == cpuPkg::BEQ || iInstr.opcode == cpuPkg::BNE) begin
        ctrl.regWen = 1'b0;
        ctrl.aluSrc = 1'b0;
        ctrl.opFunc = (iInstr.opcode == cpuPkg::BEQ) ? cpuPkg::OBEQ : cpuPkg::OBNE;
      end

      if (iInstr.opcode == cpuPkg::LUI) begin
        ctrl.opFunc = cpuPkg::OLUI;
        ctrl.wbSel  = cpuPkg::PORTB;
        ctrl.extOp  = cpuPkg::LUIEXT;
      end

      if (iInstr.opcode == cpuPkg::LW) begin
        ctrl.opFunc = cpuPkg::OLW;
        ctrl.wbSel  = cpuPkg::DLOAD;
        ctrl.dRen   = 1'b1;
      end

      if (iInstr.opcode == cpuPkg::SW) begin
        ctrl.opFunc = cpuPkg::OSW;
        ctrl.regWen = 1'b0;
        ctrl.dWen   = 1'b1;
      end

      if (iInstr.opcode == cpuPkg::ANDI || iInstr.opcode == cpuPkg::ORI ||
          iInstr.opcode == cpuPkg::XORI) begin
        ctrl.extOp = cpuPkg::ZEROEXT;  // logic immediates
      end

      case (iInstr.opcode)
        cpuPkg::ADDI, cpuPkg::ADDIU: ctrl.aluOp = cpuPkg::ALU_ADD;
        cpuPkg::LW, cpuPkg::SW:      ctrl.aluOp = cpuPkg::ALU_ADD;
        cpuPkg::BEQ, cpuPkg::BNE:    ctrl.aluOp = cpuPkg::ALU_SUB;
        cpuPkg::ANDI:  ctrl.aluOp = cpuPkg::ALU_AND;
        cpuPkg::ORI:   ctrl.aluOp = cpuPkg::ALU_OR;
        cpuPkg::XORI:  ctrl.aluOp = cpuPkg::ALU_XOR;
        cpuPkg::SLTI:  ctrl.aluOp = cpuPkg::ALU_SLT;
        cpuPkg::SLTIU: ctrl.aluOp = cpuPkg::ALU_SLTU;
        default:       ctrl.aluOp = cpuPkg::ALU_AND;
      endcase
    end else if (isJ) begin
      if (jInstr.opcode == cpuPkg::JAL) begin
        ctrl.opFunc = cpuPkg::OJAL;
        ctrl.regWen = 1'b1;  // link into r31
      end else begin
        ctrl.opFunc = cpuPkg::OJ;
      end
    end else if (isHalt) begin
      ctrl.halt = 1'b1;
    end
  end

endmodule

//--- verilog/aluUnit.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module aluUnit (
  input  cpuPkg::aluOpT      aluOp,
  input  logic [`WORD_W-1:0] a,
  input  logic [`WORD_W-1:0] b,
  output logic [`WORD_W-1:0] result,
  output logic               zero
);

  always_comb begin
    case (aluOp)
      cpuPkg::ALU_ADD: result = a + b;
      cpuPkg::ALU_SUB: result = a - b;
      cpuPkg::ALU_AND: result = a & b;
      cpuPkg::ALU_OR:  result = a | b;
      cpuPkg::ALU_XOR: result = a ^ b;
      cpuPkg::ALU_NOR: result = ~(a | b);
      cpuPkg::ALU_SLT: begin
        result = '0;
        result[0] = ($signed(a) < $signed(b));
      end
      cpuPkg::ALU_SLTU: begin
        result = '0;
        result[0] = (a < b);
      end
      cpuPkg::ALU_SLL: result = a << b[4:0];  // amount is low 5 bits
      cpuPkg::ALU_SRL: result = a >> b[4:0];
      default:         result = '0;
    endcase
  end

  // branches use this after SUB
  assign zero = (result == '0);

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module registerFile (
  input  logic               CLK,
  input  logic               rstN,
  input  logic [`REG_AW-1:0] raddrA,
  input  logic [`REG_AW-1:0] raddrB,
  output logic [`WORD_W-1:0] rdataA,
  output logic [`WORD_W-1:0] rdataB,
  input  cpuPkg::regWriteT   wr
);

  logic [`WORD_W-1:0] regs [`REG_CNT];

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      for (int i = 0; i < `REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.wen && wr.addr != '0) begin
      regs[wr.addr] <= wr.data;
    end
  end

  // r0 always reads zero
  assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
  assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

//--- verilog/extendSelect.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module extendSelect (
  input  cpuPkg::ctrlT       ctrl,
  input  logic [`WORD_W-1:0] instr,
  input  logic [`WORD_W-1:0] rdataB,
  output logic [`WORD_W-1:0] portB,
  output logic [`WORD_W-1:0] extImm
);

  cpuPkg::iInstrT iInstr;
  cpuPkg::rInstrT rInstr;

  assign iInstr = cpuPkg::iInstrT'(instr);
  assign rInstr = cpuPkg::rInstrT'(instr);

  always_comb begin
    case (ctrl.extOp)
      cpuPkg::ZEROEXT: extImm = {{(`WORD_W-16){1'b0}}, iInstr.imm};
      cpuPkg::SIGNEXT: extImm = {{(`WORD_W-16){iInstr.imm[15]}}, iInstr.imm};
      cpuPkg::LUIEXT:  extImm = {iInstr.imm, {(`WORD_W-16){1'b0}}};
      cpuPkg::SHAMEXT: extImm = {{(`WORD_W-5){1'b0}}, rInstr.shamt};
      default:         extImm = '0;
    endcase
  end

  assign portB = ctrl.aluSrc ? extImm : rdataB;

endmodule

//--- verilog/nextPcLogic.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module nextPcLogic (
  input  cpuPkg::ctrlT       ctrl,
  input  logic               zero,
  input  logic [`WORD_W-1:0] npc,
  input  logic [`WORD_W-1:0] instr,
  input  logic [`WORD_W-1:0] rdataA,
  output cpuPkg::redirectT   redirect
);

  cpuPkg::iInstrT iInstr;
  cpuPkg::jInstrT jInstr;
  logic [`WORD_W-1:0] branchTarget;
  logic [`WORD_W-1:0] jumpTarget;

  assign iInstr = cpuPkg::iInstrT'(instr);
  assign jInstr = cpuPkg::jInstrT'(instr);

  // word offset relative to npc
  assign branchTarget = npc + {{(`WORD_W-18){iInstr.imm[15]}}, iInstr.imm, 2'b00};
  assign jumpTarget = {npc[`WORD_W-1 -: 4], jInstr.index, 2'b00};  // pseudo-direct

  always_comb begin
    redirect.taken  = 1'b0;
    redirect.target = npc;
    case (ctrl.opFunc)
      cpuPkg::OBEQ: begin
        redirect.taken = zero;
        if (zero) redirect.target = branchTarget;
      end
      cpuPkg::OBNE: begin
        redirect.taken = !zero;
        if (!zero) redirect.target = branchTarget;
      end
      cpuPkg::OJ, cpuPkg::OJAL: begin
        redirect.taken  = 1'b1;
        redirect.target = jumpTarget;
      end
      cpuPkg::OJR: begin
        redirect.taken  = 1'b1;
        redirect.target = rdataA;
      end
      default: ;
    endcase
  end

endmodule

//--- verilog/mipsExecCore.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module mipsExecCore (
  input  logic               CLK,
  input  logic               rstN,
  input  logic [`WORD_W-1:0] instr,
  input  logic [`WORD_W-1:0] npc,
  input  logic [`WORD_W-1:0] dload,
  output cpuPkg::memReqT     memReq,
  output cpuPkg::redirectT   redirect,
  output cpuPkg::regWriteT   regWrite,
  output logic               halt
);

  cpuPkg::ctrlT   ctrl;
  cpuPkg::rInstrT rInstr;

  logic [`WORD_W-1:0] rdataA, rdataB;
  logic [`WORD_W-1:0] portB, extImm;
  logic [`WORD_W-1:0] aluA, aluResult;
  logic               aluZero;
  logic [`REG_AW-1:0] dstAddr;
  logic [`WORD_W-1:0] wbData;

  assign rInstr = cpuPkg::rInstrT'(instr);

  controlUnit uCtrl (
    .instr (instr),
    .ctrl  (ctrl)
  );

  registerFile uRegs (
    .CLK    (CLK),
    .rstN   (rstN),
    .raddrA (rInstr.rs),
    .raddrB (rInstr.rt),
    .rdataA (rdataA),
    .rdataB (rdataB),
    .wr     (regWrite)
  );

  extendSelect uExt (
    .ctrl   (ctrl),
    .instr  (instr),
    .rdataB (rdataB),
    .portB  (portB),
    .extImm (extImm)
  );

  // shifts operate on rt with the amount on port B
  assign aluA = (ctrl.opFunc == cpuPkg::OSL) ? rdataB : rdataA;

  aluUnit uAlu (
    .aluOp  (ctrl.aluOp),
    .a      (aluA),
    .b      (portB),
    .result (aluResult),
    .zero   (aluZero)
  );

  nextPcLogic uNextPc (
    .ctrl     (ctrl),
    .zero     (aluZero),
    .npc      (npc),
    .instr    (instr),
    .rdataA   (rdataA),
    .redirect (redirect)
  );

  always_comb begin
    case (ctrl.regDst)
      cpuPkg::RD:  dstAddr = rInstr.rd;
      cpuPkg::RT:  dstAddr = rInstr.rt;
      default:     dstAddr = `REG_AW'd31;  // link register
    endcase
    case (ctrl.wbSel)
      cpuPkg::ALUO:  wbData = aluResult;
      cpuPkg::DLOAD: wbData = dload;
      cpuPkg::PORTB: wbData = extImm;
      default:       wbData = npc;
    endcase
  end

  assign memReq.dRen      = ctrl.dRen;
  assign memReq.dWen      = ctrl.dWen;
  assign memReq.addr      = aluResult;
  assign memReq.storeData = rdataB;

  assign regWrite.wen  = ctrl.regWen;
  assign regWrite.addr = dstAddr;
  assign regWrite.data = wbData;

  assign halt = ctrl.halt;

endmodule

//--- tb/mipsExecCore_properties.sv
`timescale 1ns/10ps

module mipsExecCore_properties (
  input logic             CLK,
  input logic             rstN,
  input cpuPkg::memReqT   memReq,
  input cpuPkg::regWriteT regWrite,
  input logic             halt
);

  // load and store never in the same cycle
  strobeExclusive: assert property (@(posedge CLK) disable iff (!rstN)
    !(memReq.dRen && memReq.dWen))
    else $error("dRen and dWen set together");

  haltQuiet: assert property (@(posedge CLK) disable iff (!rstN)
    halt |-> (!regWrite.wen && !memReq.dWen))
    else $error("halt raised with a register write or a store");

  // register file still clear in the first cycle out of reset
  resetCleared: assert property (@(posedge CLK)
    ($rose(rstN) && memReq.dWen) |-> (memReq.storeData == '0))
    else $error("store data not zero right after reset");

endmodule

bind mipsExecCore mipsExecCore_properties uProps (
  .CLK      (CLK),
  .rstN     (rstN),
  .memReq   (memReq),
  .regWrite (regWrite),
  .halt     (halt)
);

//--- tb/mipsExecCore_tb.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module mipsExecCore_tb;

  localparam int MAX_CYCLES = 200;
  localparam cpuPkg::regWriteT NOWR = '0;
  localparam cpuPkg::memReqT NOMEM = '0;
  localparam cpuPkg::redirectT NOJMP = '0;

  typedef struct packed {
    logic [`WORD_W-1:0] instr;
    logic [`WORD_W-1:0] npc;
    logic [`WORD_W-1:0] dload;  // what memory returns this cycle
    cpuPkg::regWriteT   wr;
    cpuPkg::memReqT     mem;
    cpuPkg::redirectT   rdr;
    logic               halt;
  } stepT;

  logic               CLK;
  logic               rstN;
  logic [`WORD_W-1:0] instr;
  logic [`WORD_W-1:0] npc;
  logic [`WORD_W-1:0] dload;
  cpuPkg::memReqT     memReq;
  cpuPkg::redirectT   redirect;
  cpuPkg::regWriteT   regWrite;
  logic               halt;

  stepT               prog[$];
  logic [`WORD_W-1:0] npcNext;
  logic               tableDone;
  int                 stepNo;

  mipsExecCore u_dut (
    .CLK      (CLK),
    .rstN     (rstN),
    .instr    (instr),
    .npc      (npc),
    .dload    (dload),
    .memReq   (memReq),
    .redirect (redirect),
    .regWrite (regWrite),
    .halt     (halt)
  );

  always #20 CLK = ~CLK;

  function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] shamt,
                                          input logic [5:0] funct);
    return {6'b000000, rs, rt, rd, shamt, funct};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] index);
    return {op, index};
  endfunction

  task automatic addStep(input logic [31:0] stepInstr, input cpuPkg::regWriteT wr,
                         input cpuPkg::memReqT mem, input cpuPkg::redirectT rdr,
                         input logic [31:0] loadData, input logic haltExp);
    stepT s;
    s.instr = stepInstr;
    s.npc   = npcNext;
    s.dload = loadData;
    s.wr    = wr;
    s.mem   = mem;
    s.rdr   = rdr;
    if (!rdr.taken) s.rdr.target = npcNext;  // falls through to npc
    s.halt  = haltExp;
    prog.push_back(s);
    npcNext = npcNext + 32'd4;
  endtask

  task automatic addWrite(input logic [31:0] stepInstr, input logic [4:0] addr,
                          input logic [31:0] data);
    addStep(stepInstr, {1'b1, addr, data}, NOMEM, NOJMP, '0, 1'b0);
  endtask

  task automatic addStore(input logic [31:0] stepInstr, input logic [31:0] addr,
                          input logic [31:0] data);
    addStep(stepInstr, NOWR, {1'b0, 1'b1, addr, data}, NOJMP, '0, 1'b0);
  endtask

  task automatic loadProgram();
    npcNext = 32'h8000_1000;
    // registers come out of reset cleared and r0 drops writes
    addStore(encodeI(cpuPkg::SW, 5'd0, 5'd5, 16'h0000), 32'h0, 32'h0);
    addWrite(encodeI(cpuPkg::ADDI, 5'd0, 5'd0, 16'h0055), 5'd0, 32'h55);
    addStore(encodeI(cpuPkg::SW, 5'd0, 5'd0, 16'h0004), 32'h4, 32'h0);
    // r1 = -5, r2 = 0xf0
    addWrite(encodeI(cpuPkg::ADDI, 5'd0, 5'd1, 16'hFFFB), 5'd1, 32'hFFFF_FFFB);
    addWrite(encodeI(cpuPkg::ORI, 5'd0, 5'd2, 16'h00F0), 5'd2, 32'hF0);
    addWrite(encodeR(5'd1, 5'd2, 5'd3, 5'd0, cpuPkg::ADD), 5'd3, 32'hEB);
    addWrite(encodeR(5'd2, 5'd1, 5'd4, 5'd0, cpuPkg::SUB), 5'd4, 32'hF5);
    addWrite(encodeR(5'd1, 5'd2, 5'd5, 5'd0, cpuPkg::AND), 5'd5, 32'hF0);
    addWrite(encodeR(5'd1, 5'd2, 5'd6, 5'd0, cpuPkg::OR), 5'd6, 32'hFFFF_FFFB);
    addWrite(encodeR(5'd1, 5'd2, 5'd7, 5'd0, cpuPkg::XOR), 5'd7, 32'hFFFF_FF0B);
    addWrite(encodeR(5'd1, 5'd2, 5'd8, 5'd0, cpuPkg::NOR), 5'd8, 32'h4);
    addWrite(encodeR(5'd1, 5'd2, 5'd9, 5'd0, cpuPkg::SLT), 5'd9, 32'h1);  // -5 < 240
    addWrite(encodeR(5'd1, 5'd2, 5'd10, 5'd0, cpuPkg::SLTU), 5'd10, 32'h0);
    addWrite(encodeR(5'd0, 5'd2, 5'd11, 5'd4, cpuPkg::SLL), 5'd11, 32'hF00);
    addWrite(encodeR(5'd0, 5'd1, 5'd12, 5'd28, cpuPkg::SRL), 5'd12, 32'hF);
    addWrite(encodeR(5'd3, 5'd4, 5'd13, 5'd0, cpuPkg::ADDU), 5'd13, 32'h1E0);
    addWrite(encodeR(5'd2, 5'd3, 5'd14, 5'd0, cpuPkg::SUBU), 5'd14, 32'h5);
    // logic immediates zero extended
    addWrite(encodeI(cpuPkg::ANDI, 5'd1, 5'd15, 16'h8F0F), 5'd15, 32'h8F0B);
    addWrite(encodeI(cpuPkg::ORI, 5'd0, 5'd16, 16'h8000), 5'd16, 32'h8000);
    addWrite(encodeI(cpuPkg::XORI, 5'd1, 5'd17, 16'hFFFF), 5'd17, 32'hFFFF_0004);
    addWrite(encodeI(cpuPkg::LUI, 5'd0, 5'd18, 16'h1234), 5'd18, 32'h1234_0000);
    addWrite(encodeI(cpuPkg::SLTI, 5'd2, 5'd19, 16'hFFFF), 5'd19, 32'h0);  // 240 not below -1
    addWrite(encodeI(cpuPkg::SLTIU, 5'd2, 5'd20, 16'hFFFF), 5'd20, 32'h1);
    addWrite(encodeI(cpuPkg::ADDIU, 5'd2, 5'd21, 16'h0010), 5'd21, 32'h100);
    // r22 loaded from r2 + 8, then stored below r18
    addStep(encodeI(cpuPkg::LW, 5'd2, 5'd22, 16'h0008), {1'b1, 5'd22, 32'hCAFE_F00D},
            {1'b1, 1'b0, 32'hF8, 32'h0}, NOJMP, 32'hCAFE_F00D, 1'b0);
    addStore(encodeI(cpuPkg::SW, 5'd18, 5'd22, 16'hFFFC), 32'h1233_FFFC, 32'hCAFE_F00D);
    // first branch sits at npc 8000_1068
    addStep(encodeI(cpuPkg::BEQ, 5'd3, 5'd3, 16'h0003), NOWR, NOMEM,
            {1'b1, 32'h8000_1074}, '0, 1'b0);
    addStep(encodeI(cpuPkg::BEQ, 5'd1, 5'd2, 16'h0003), NOWR, NOMEM, NOJMP, '0, 1'b0);
    addStep(encodeI(cpuPkg::BNE, 5'd1, 5'd2, 16'hFFFE), NOWR, NOMEM,
            {1'b1, 32'h8000_1068}, '0, 1'b0);
    addStep(encodeI(cpuPkg::BNE, 5'd2, 5'd5, 16'h0010), NOWR, NOMEM, NOJMP, '0, 1'b0);
    addStep(encodeJ(cpuPkg::J, 26'h012_3456), NOWR, NOMEM, {1'b1, 32'h8048_D158}, '0, 1'b0);
    addStep(encodeJ(cpuPkg::JAL, 26'h3FF_FFFF), {1'b1, 5'd31, 32'h8000_107C}, NOMEM,
            {1'b1, 32'h8FFF_FFFC}, '0, 1'b0);
    addStep(encodeR(5'd18, 5'd0, 5'd0, 5'd0, cpuPkg::JR), NOWR, NOMEM,
            {1'b1, 32'h1234_0000}, '0, 1'b0);
    addStore(encodeI(cpuPkg::SW, 5'd0, 5'd31, 16'h0000), 32'h0, 32'h8000_107C);
    addStep(encodeJ(cpuPkg::HALT, 26'h0), NOWR, NOMEM, NOJMP, '0, 1'b1);
    addStep(encodeJ(6'h10, 26'h0), NOWR, NOMEM, NOJMP, '0, 1'b0);  // cop0 is not decoded
  endtask

  task automatic checkValue(input string field, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t: step %0d %s is %h, expected %h",
               $time, stepNo, field, actual, expected);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", field);
    end
  endtask

  task automatic checkStep(input stepT s);
    checkValue("regWrite.wen", 32'(regWrite.wen), 32'(s.wr.wen));
    if (s.wr.wen) begin
      checkValue("regWrite.addr", 32'(regWrite.addr), 32'(s.wr.addr));
      checkValue("regWrite.data", regWrite.data, s.wr.data);
    end
    checkValue("memReq.dRen", 32'(memReq.dRen), 32'(s.mem.dRen));
    checkValue("memReq.dWen", 32'(memReq.dWen), 32'(s.mem.dWen));
    if (s.mem.dRen || s.mem.dWen) checkValue("memReq.addr", memReq.addr, s.mem.addr);
    if (s.mem.dWen) checkValue("memReq.storeData", memReq.storeData, s.mem.storeData);
    checkValue("redirect.taken", 32'(redirect.taken), 32'(s.rdr.taken));
    checkValue("redirect.target", redirect.target, s.rdr.target);
    checkValue("halt", 32'(halt), 32'(s.halt));
  endtask

  initial begin : stimulus
    CLK       = 1'b0;
    rstN      = 1'b0;
    instr     = '0;  // nop while in reset
    npc       = '0;
    dload     = '0;
    tableDone = 1'b0;
    stepNo    = 0;
    loadProgram();
    repeat (10) @(posedge CLK);
    for (int k = 0; k < prog.size(); k++) begin
      @(negedge CLK);
      rstN   = 1'b1;  // released together with the first step
      stepNo = k;
      instr  = prog[k].instr;
      npc    = prog[k].npc;
      dload  = prog[k].dload;
      #15;
      checkStep(prog[k]);
    end
    tableDone = 1'b1;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (!tableDone && cycles < MAX_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    if (tableDone) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("timeout after %0d cycles, the program table never finished", cycles);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

endmodule

//--- flist.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/controlUnit.sv
verilog/aluUnit.sv
verilog/registerFile.sv
verilog/extendSelect.sv
verilog/nextPcLogic.sv
verilog/mipsExecCore.sv
tb/mipsExecCore_properties.sv
tb/mipsExecCore_tb.sv

//--- Makefile
TOP = mipsExecCore_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f verilog/cpu_cfg.svh $(wildcard verilog/*.sv tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f flist.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/10ps \
		-f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
